/* avr_decode_pkg.sv */
package avr_decode_pkg;

    // Register file has 32 entries
    localparam int r_addr_width = 5;

    // Widest immediate belongs to RJMP and RCALL
    localparam int imd_width = 12;

    // Status register location in I/O space
    localparam logic [imd_width-1:0] sreg_io_addr = 12'd63;

    // Global interrupt enable position inside SREG
    localparam logic [2:0] flag_i_bit = 3'd7;

    // Decoded instruction kinds
    typedef enum logic [4:0] {
        type_nop,
        type_add,
        type_adc,
        type_sub,
        type_and,
        type_or,
        type_eor,
        type_cp,
        type_mov,
        type_inc,
        type_dec,
        type_neg,
        type_ldi,
        type_subi,
        type_brbs,
        type_brbc,
        type_rjmp,
        type_rcall,
        type_ret,
        type_reti,
        type_push,
        type_pop,
        type_in,
        type_out,
        type_sbi,
        type_cbi,
        type_sei,
        type_cli,
        // Virtual instruction injected on an interrupt request
        type_call_isr,
        type_unknown
    } opcode_type_t;

    // Control groups used by later pipeline stages
    typedef struct packed {
        // Read-modify-write of a single I/O bit
        logic alu_aux;
        logic alu_imd;
        logic alu_one_op;
        logic alu_two_op;
        logic alu;
        logic load;
        logic store;
        logic stack;
        logic memory;
        logic register_move;
        logic control_flow;
        logic io_read;
        logic io_write;
    } opcode_group_t;

    // Two-register layout, rr split around rd
    typedef struct packed {
        logic [5:0]              opcode;
        logic                    rr_hi;
        logic [r_addr_width-1:0] rd;
        logic [3:0]              rr_lo;
    } reg_form_t;

    // Register-immediate layout, rd limited to r16..r31
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] k_hi;
        logic [3:0] rd_lo;
        logic [3:0] k_lo;
    } imd_form_t;

    // Same 16-bit word seen through either layout
    typedef union packed {
        reg_form_t reg_form;
        imd_form_t imd_form;
    } instr_word_u;

    // Operand fields pulled out of one instruction
    typedef struct packed {
        logic [r_addr_width-1:0] rd;
        logic [r_addr_width-1:0] rr;
        logic [2:0]              bit_num;
        logic [imd_width-1:0]    imd;
    } operands_t;

    // Input beat
    typedef struct packed {
        instr_word_u instr;
        logic        irq;
    } decode_req_t;

    // Output beat
    typedef struct packed {
        opcode_type_t  opcode_type;
        opcode_group_t opcode_group;
        operands_t     operands;
    } decoded_t;

endpackage

/* opcode_matcher.sv */
`timescale 1ns/100ps

module opcode_matcher
    import avr_decode_pkg::*;
(
    input  decode_req_t  req,
    output opcode_type_t opcode_type
);

    always_comb begin
        if (req.irq) begin
            // Pending interrupt wins over whatever word is present
            opcode_type = type_call_isr;
        end else begin
            casez (req.instr)
                // Fully fixed encodings first
                16'b0000_0000_0000_0000: opcode_type = type_nop;
                16'b1001_0101_0000_1000: opcode_type = type_ret;
                16'b1001_0101_0001_1000: opcode_type = type_reti;
                16'b1001_0100_0111_1000: opcode_type = type_sei;
                16'b1001_0100_1111_1000: opcode_type = type_cli;

                // Two-register arithmetic and logic
                16'b0000_11??_????_????: opcode_type = type_add;
                16'b0001_11??_????_????: opcode_type = type_adc;
                16'b0001_10??_????_????: opcode_type = type_sub;
                16'b0001_01??_????_????: opcode_type = type_cp;
                16'b0010_00??_????_????: opcode_type = type_and;
                16'b0010_01??_????_????: opcode_type = type_eor;
                16'b0010_10??_????_????: opcode_type = type_or;
                16'b0010_11??_????_????: opcode_type = type_mov;

                // Single register, low nibble selects the operation
                16'b1001_010?_????_0011: opcode_type = type_inc;
                16'b1001_010?_????_1010: opcode_type = type_dec;
                16'b1001_010?_????_0001: opcode_type = type_neg;

                // Register with 8-bit constant
                16'b1110_????_????_????: opcode_type = type_ldi;
                16'b0101_????_????_????: opcode_type = type_subi;

                // Branches on an SREG bit
                16'b1111_00??_????_????: opcode_type = type_brbs;
                16'b1111_01??_????_????: opcode_type = type_brbc;

                // Relative jump and call
                16'b1100_????_????_????: opcode_type = type_rjmp;
                16'b1101_????_????_????: opcode_type = type_rcall;

                // Stack
                16'b1001_001?_????_1111: opcode_type = type_push;
                16'b1001_000?_????_1111: opcode_type = type_pop;

                // I/O space
                16'b1011_0???_????_????: opcode_type = type_in;
                16'b1011_1???_????_????: opcode_type = type_out;
                16'b1001_1010_????_????: opcode_type = type_sbi;
                16'b1001_1000_????_????: opcode_type = type_cbi;

                default:                 opcode_type = type_unknown;
            endcase
        end
    end

endmodule

/* operand_extract.sv */
`timescale 1ns/100ps

module operand_extract
    import avr_decode_pkg::*;
(
    input  instr_word_u instr,
    output operands_t   operands
);

    // Sign bit of the 7-bit branch offset
    logic branch_sign;

    assign branch_sign = instr[9];

    always_comb begin
        // Fields a format does not define stay at zero
        operands = '0;

        casez (instr[15:8])
            // LDI and SUBI, immediate layout
            8'b1110_????,
            8'b0101_????: begin
                operands.rd  = {1'b1, instr.imd_form.rd_lo};
                operands.imd = {4'b0000, instr.imd_form.k_hi, instr.imd_form.k_lo};
            end

            // BRBS and BRBC, word offset in bits 9..3
            8'b1111_0???: begin
                operands.bit_num = instr[2:0];
                operands.imd     = {{(imd_width - 7){branch_sign}}, instr[9:3]};
            end

            // SBI and CBI, low I/O address plus bit index
            8'b1001_10?0: begin
                operands.bit_num = instr[2:0];
                operands.imd     = {7'b0000000, instr[7:3]};
            end

            // IN and OUT, 6-bit I/O address split around the register
            8'b1011_????: begin
                operands.rd  = instr.reg_form.rd;
                operands.imd = {6'b000000, instr[10:9], instr[3:0]};
            end

            // RJMP and RCALL
            8'b110?_????: begin
                operands.imd = instr[11:0];
            end

            // Everything else uses the two-register layout
            default: begin
                operands.rd = instr.reg_form.rd;
                operands.rr = {instr.reg_form.rr_hi, instr.reg_form.rr_lo};
            end
        endcase
    end

endmodule

/* group_classifier.sv */
`timescale 1ns/100ps

module group_classifier
    import avr_decode_pkg::*;
(
    input  opcode_type_t opcode_type,
    input  operands_t    operands,
    output decoded_t     result
);

    opcode_group_t grp;
    operands_t     ops;

    always_comb begin
        grp = '0;

        // SEI and CLI behave as SBI and CBI on SREG
        grp.alu_aux = opcode_type inside {type_sbi, type_cbi, type_sei, type_cli,
                                          type_reti, type_call_isr};
        grp.alu_imd = opcode_type inside {type_inc, type_dec};
        grp.alu_one_op = (opcode_type == type_neg);
        grp.alu_two_op = opcode_type inside {type_add, type_adc, type_sub, type_and,
                                             type_eor, type_or, type_cp};
        grp.alu = grp.alu_one_op || grp.alu_two_op;

        // Stack pops and pushes, the return address included
        grp.load  = opcode_type inside {type_pop, type_ret, type_reti};
        grp.store = opcode_type inside {type_push, type_rcall, type_call_isr};
        grp.stack = grp.load || grp.store;
        grp.memory = grp.load || grp.store;

        grp.register_move = opcode_type inside {type_ldi, type_mov};
        grp.control_flow = opcode_type inside {type_brbs, type_brbc, type_rjmp,
                                               type_rcall, type_ret, type_reti,
                                               type_call_isr};

        // ADC reads the carry out of SREG, stack ops touch SP
        grp.io_read  = (opcode_type inside {type_in, type_adc}) ||
                       grp.stack || grp.alu_aux;
        // ALU results update SREG
        grp.io_write = (opcode_type == type_out) ||
                       grp.alu || grp.stack || grp.alu_aux;
    end

    always_comb begin
        ops = operands;

        case (opcode_type)
            // Implied operand is the I flag in SREG
            type_sei, type_cli, type_call_isr: begin
                ops.bit_num = flag_i_bit;
                ops.imd     = sreg_io_addr;
            end
            // Register is a source here
            type_out, type_push: begin
                ops.rr = operands.rd;
                ops.rd = '0;
            end
            // Register is a destination here
            type_in, type_pop: begin
                ops.rd = operands.rd;
                ops.rr = '0;
            end
            default: ops = operands;
        endcase
    end

    assign result.opcode_type  = opcode_type;
    assign result.opcode_group = grp;
    assign result.operands     = ops;

endmodule

/* avr_decode.sv */
`timescale 1ns/100ps

module avr_decode
    import avr_decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  decode_req_t in_beat,
    output logic        out_valid,
    input  logic        out_ready,
    output decoded_t    out_beat
);

    opcode_type_t opcode_type;
    operands_t    operands;
    decoded_t     result;
    logic         accept;

    // Classification and field extraction run side by side
    opcode_matcher opcode_matcher_i (
        .req         (in_beat),
        .opcode_type (opcode_type)
    );

    operand_extract operand_extract_i (
        .instr    (in_beat.instr),
        .operands (operands)
    );

    group_classifier group_classifier_i (
        .opcode_type (opcode_type),
        .operands    (operands),
        .result      (result)
    );

    // Room when the slot is empty or is being drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only loads on an accepted beat
    always_ff @(posedge clk) begin
        if (accept) begin
            out_beat <= result;
        end
    end

endmodule

/* avr_decode_assert.sv */
`timescale 1ns/100ps

module avr_decode_assert
    import avr_decode_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        in_ready,
    input decode_req_t in_beat,
    input logic        out_valid,
    input logic        out_ready,
    input decoded_t    out_beat
);

    decode_req_t  held;
    decoded_t     last_beat;
    logic [15:0]  word;
    opcode_type_t k_type;
    opcode_type_t br_type;
    logic         is_alu_two;
    logic         is_k_form;
    logic         is_branch;
    logic         is_ones;

    // Expected value next to what the DUT returns, one pair per check
    logic [16:0]  exp_reg;
    logic [16:0]  act_reg;
    logic [21:0]  exp_k;
    logic [21:0]  act_k;
    logic [20:0]  exp_branch;
    logic [20:0]  act_branch;
    logic [23:0]  exp_irq;
    logic [23:0]  act_irq;
    logic [17:0]  exp_unknown;
    logic [17:0]  act_unknown;

    int fail_reset = 0;
    int fail_ready = 0;
    int fail_hold = 0;
    int fail_irq = 0;
    int fail_reg = 0;
    int fail_k = 0;
    int fail_branch = 0;
    int fail_unknown = 0;
    int fail_count;

    // Two-register ALU opcodes from the instruction set table
    function automatic opcode_type_t alu_two_op_type(input logic [5:0] op);
        case (op)
            6'b000011: return type_add;
            6'b000111: return type_adc;
            6'b000110: return type_sub;
            6'b000101: return type_cp;
            6'b001000: return type_and;
            6'b001001: return type_eor;
            6'b001010: return type_or;
            default:   return type_unknown;
        endcase
    endfunction

    // Copy of the beat that the current output belongs to
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_beat;
        end
        last_beat <= out_beat;
    end

    assign word       = held.instr;
    assign k_type     = (word[15:12] == 4'b1110) ? type_ldi : type_subi;
    assign br_type    = word[10] ? type_brbc : type_brbs;
    assign is_alu_two = !held.irq && (alu_two_op_type(word[15:10]) != type_unknown);
    assign is_k_form  = !held.irq && (word[15:12] == 4'b1110 || word[15:12] == 4'b0101);
    assign is_branch  = !held.irq && (word[15:11] == 5'b11110);
    assign is_ones    = !held.irq && (word == 16'hffff);

    assign exp_reg = {alu_two_op_type(word[15:10]), word[8:4], word[9], word[3:0], 2'b11};
    assign act_reg = {out_beat.opcode_type, out_beat.operands.rd, out_beat.operands.rr,
                      out_beat.opcode_group.alu_two_op, out_beat.opcode_group.io_write};

    assign exp_k = {k_type, 1'b1, word[7:4], 4'b0000, word[11:8], word[3:0]};
    assign act_k = {out_beat.opcode_type, out_beat.operands.rd, out_beat.operands.imd};

    // Branch offset is sign extended from bit 9
    assign exp_branch = {br_type, word[2:0], {5{word[9]}}, word[9:3], 1'b1};
    assign act_branch = {out_beat.opcode_type, out_beat.operands.bit_num,
                         out_beat.operands.imd, out_beat.opcode_group.control_flow};

    assign exp_irq = {type_call_isr, flag_i_bit, sreg_io_addr, 4'b1111};
    assign act_irq = {out_beat.opcode_type, out_beat.operands.bit_num, out_beat.operands.imd,
                      out_beat.opcode_group.alu_aux, out_beat.opcode_group.store,
                      out_beat.opcode_group.stack, out_beat.opcode_group.control_flow};

    assign exp_unknown = {type_unknown, 13'd0};
    assign act_unknown = {out_beat.opcode_type, out_beat.opcode_group};

    assign fail_count = fail_reset + fail_ready + fail_hold + fail_irq + fail_reg +
                        fail_k + fail_branch + fail_unknown;

    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_reset = fail_reset + 1;
            $error("error reset: expected 0, actual %b", out_valid);
        end

    assert property (@(posedge clk) disable iff (reset) in_ready == (!out_valid || out_ready))
        else begin
            fail_ready = fail_ready + 1;
            $error("error in_ready: expected %b, actual %b", !out_valid || out_ready, in_ready);
        end

    // Stalled result stays valid and unchanged
    assert property (@(posedge clk) disable iff (reset)
                     out_valid && !out_ready |=> out_valid && out_beat == last_beat)
        else begin
            fail_hold = fail_hold + 1;
            $error("error back_pressure: expected %h, actual %h",
                   {1'b1, last_beat}, {out_valid, out_beat});
        end

    assert property (@(posedge clk) disable iff (reset)
                     out_valid && held.irq |-> act_irq == exp_irq)
        else begin
            fail_irq = fail_irq + 1;
            $error("error irq_override: expected %h, actual %h", exp_irq, act_irq);
        end

    assert property (@(posedge clk) disable iff (reset)
                     out_valid && is_alu_two |-> act_reg == exp_reg)
        else begin
            fail_reg = fail_reg + 1;
            $error("error reg_operands: expected %h, actual %h", exp_reg, act_reg);
        end

    assert property (@(posedge clk) disable iff (reset)
                     out_valid && is_k_form |-> act_k == exp_k)
        else begin
            fail_k = fail_k + 1;
            $error("error imd_operands: expected %h, actual %h", exp_k, act_k);
        end

    assert property (@(posedge clk) disable iff (reset)
                     out_valid && is_branch |-> act_branch == exp_branch)
        else begin
            fail_branch = fail_branch + 1;
            $error("error branch_operands: expected %h, actual %h", exp_branch, act_branch);
        end

    assert property (@(posedge clk) disable iff (reset)
                     out_valid && is_ones |-> act_unknown == exp_unknown)
        else begin
            fail_unknown = fail_unknown + 1;
            $error("error unknown_word: expected %h, actual %h", exp_unknown, act_unknown);
        end

endmodule

/* tb_avr_decode.sv */
`timescale 1ns/100ps

module tb_avr_decode
    import avr_decode_pkg::*;
;

    localparam int reset_cycles = 16;
    localparam int num_beats = 400;
    // Four cycles per beat covers gaps and stalls, the rest is margin
    localparam int max_cycles = reset_cycles + num_beats * 4 + 384;
    localparam int num_templates = 29;

    // Fixed bits of each kept instruction, then the mask of its operand bits
    localparam logic [31:0] templates [0:num_templates-1] = '{
        32'h0000_0000, 32'h0c00_03ff, 32'h1c00_03ff, 32'h1800_03ff,
        32'h2000_03ff, 32'h2800_03ff, 32'h2400_03ff, 32'h1400_03ff,
        32'h2c00_03ff, 32'h9403_01f0, 32'h940a_01f0, 32'h9401_01f0,
        32'he000_0fff, 32'h5000_0fff, 32'hf000_03ff, 32'hf400_03ff,
        32'hc000_0fff, 32'hd000_0fff, 32'h9508_0000, 32'h9518_0000,
        32'h920f_01f0, 32'h900f_01f0, 32'hb000_07ff, 32'hb800_07ff,
        32'h9a00_00ff, 32'h9800_00ff, 32'h9478_0000, 32'h94f8_0000,
        32'hffff_0000
    };

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    decode_req_t in_beat;
    logic        out_valid;
    logic        out_ready;
    decoded_t    out_beat;

    logic [31:0] lfsr_state;
    int          accepted_beats;
    int          cycle_count = 0;

    avr_decode avr_decode_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    bind avr_decode avr_decode_assert avr_decode_assert_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[14:0], lfsr_state[0]};
        end
    endtask

    task automatic make_beat(output decode_req_t req);
        logic [15:0] pick;
        logic [15:0] fill;
        logic [15:0] irq_bits;
        int          idx;
        draw_bits(5, pick);
        idx = pick % num_templates;
        draw_bits(16, fill);
        draw_bits(3, irq_bits);
        req.instr = templates[idx][31:16] | (fill & templates[idx][15:0]);
        req.irq = (irq_bits[2:0] == 3'b000);
    endtask

    // One falling edge, with a fresh random out_ready
    task automatic next_cycle();
        logic [15:0] r;
        @(negedge clk);
        draw_bits(1, r);
        out_ready = r[0];
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            accepted_beats <= 0;
        end else if (in_valid && in_ready) begin
            accepted_beats <= accepted_beats + 1;
        end
    end

    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (avr_decode_i.avr_decode_assert_i.fail_count != 0) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checker reported a failing assertion");
        end else if (cycle_count >= max_cycles) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout after %0d cycles with %0d beats taken", cycle_count,
                   accepted_beats);
        end
    end

    initial begin
        logic [15:0] gap;
        decode_req_t req;
        int          beat;
        lfsr_state = 32'he0eb;
        reset = 1'b1;
        in_valid = 1'b0;
        in_beat = '0;
        out_ready = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        for (beat = 0; beat < num_beats; beat++) begin
            // Idle cycle before about one beat in four
            draw_bits(2, gap);
            if (gap[1:0] == 2'b00) begin
                in_valid = 1'b0;
                next_cycle();
            end
            make_beat(req);
            in_beat = req;
            in_valid = 1'b1;
            do begin
                next_cycle();
            end while (accepted_beats == beat);
        end

        // Drain the last result
        in_valid = 1'b0;
        out_ready = 1'b1;
        while (out_valid) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        if (avr_decode_i.avr_decode_assert_i.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checker reported a failing assertion");
        end
    end

endmodule

/* build.f */
avr_decode_pkg.sv
opcode_matcher.sv
operand_extract.sv
group_classifier.sv
avr_decode.sv
avr_decode_assert.sv
tb_avr_decode.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_avr_decode
FILELIST  = build.f
OBJ_DIR   = obj_dir
RUNFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)
